//--- verilog.f
rtl/offload_pkg.sv
rtl/ipu_pkg.sv
rtl/spill_register.sv
rtl/offload_switch.sv
rtl/int_unit.sv
rtl/core_complex.sv
verif/core_complex_sva.sv
verif/offload_checker.sv
verif/tb_core_complex.sv

//--- Makefile
# Verilator build for the offload core complex

VERILATOR ?= verilator
TOP       ?= tb_core_complex
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "^NO ERRORS$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- verif/offload_input.txt
# test unit op id arga argb sh_data sh_err exp_data exp_err
# test in decimal, all other columns in hex; unit 0 integer, 1 shared
1 0 0 01 00000005 00000003 00000000 0 00000008 0
2 0 1 02 00000003 00000005 00000000 0 FFFFFFFE 0
3 0 2 03 00001234 00000010 00000000 0 00012340 0
4 0 3 04 F0F0F0F0 FF00FF00 00000000 0 F000F000 0
5 0 4 05 F0F0F0F0 0F0F0000 00000000 0 FFFFF0F0 0
6 0 5 06 AAAA5555 FFFF0000 00000000 0 55555555 0
7 0 6 07 00000001 00000024 00000000 0 00000010 0
8 0 7 08 80000000 0000001F 00000000 0 00000001 0
9 0 9 09 11111111 22222222 00000000 0 00000000 1
10 1 2 0A 00000007 00000006 DEADBEEF 0 DEADBEEF 0
11 1 A 0B 00000001 00000002 00000000 1 00000000 1
12 0 0 0C FFFFFFFF 00000001 00000000 0 00000000 0
13 1 0 0D 00000000 00000000 12345678 0 12345678 0
14 0 2 0E 00010000 00010000 00000000 0 00000000 0
15 1 5 0F 0000FFFF 00FF00FF CAFEF00D 0 CAFEF00D 0
16 0 6 10 80000001 00000001 00000000 0 00000002 0

//--- verif/tb_core_complex.sv
// ----------------------------------------
// Testbench: clock, reset, file stimulus,
// shared-unit model and DUT instance
// ----------------------------------------
`timescale 1ns/1ns

module tb_core_complex;

  localparam int DriveDelay   = 1;
  localparam int ReqTimeout   = 500;
  localparam int RdyTimeout   = 20;
  localparam int DrainTimeout = 3000;

  logic        clk_i = 1'b0;
  logic        rst_ni;
  logic        req_valid_i;
  offload_pkg::unit_sel_e req_unit_i;
  logic [4:0]  req_id_i;
  logic [3:0]  req_op_i;
  logic [31:0] req_arga_i, req_argb_i;
  logic        req_ready_o;
  logic        resp_valid_o, resp_error_o;
  logic        resp_ready_i = 1'b0;
  logic [31:0] resp_data_o;
  logic [4:0]  resp_id_o;
  logic        sh_req_valid_o;
  logic        sh_req_ready_i = 1'b0;
  logic [4:0]  sh_req_id_o;
  logic [3:0]  sh_req_op_o;
  logic [31:0] sh_req_arga_o, sh_req_argb_o;
  logic        sh_resp_valid_i = 1'b0;
  logic [31:0] sh_resp_data_i = '0;
  logic [4:0]  sh_resp_id_i = '0;
  logic        sh_resp_error_i = 1'b0;
  logic        sh_resp_ready_o;

  logic [7:0]  exp_test;
  logic [31:0] exp_data;
  logic        exp_error;
  int          chk_errors, chk_done;
  int          tb_errors;
  int          num_reqs;
  integer      seed = 32'h61b0_ddd1;
  logic [31:0] rnd;

  // Shared-unit model state
  logic [32:0] reply_q[$];
  logic [37:0] pend_q[$];
  logic [32:0] reply;
  logic [37:0] pend;
  logic        sh_done;

  always #5 clk_i = ~clk_i;

  core_complex #(
    .RegisterReq  ( 1'b1 ),
    .RegisterResp ( 1'b1 )
  ) i_core_complex (.*);

  offload_checker i_checker (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .req_valid_i    ( req_valid_i    ),
    .req_ready_i    ( req_ready_o    ),
    .req_unit_i     ( req_unit_i     ),
    .req_id_i       ( req_id_i       ),
    .req_op_i       ( req_op_i       ),
    .req_arga_i     ( req_arga_i     ),
    .req_argb_i     ( req_argb_i     ),
    .exp_test_i     ( exp_test       ),
    .exp_data_i     ( exp_data       ),
    .exp_error_i    ( exp_error      ),
    .sh_req_valid_i ( sh_req_valid_o ),
    .sh_req_ready_i ( sh_req_ready_i ),
    .sh_req_id_i    ( sh_req_id_o    ),
    .sh_req_op_i    ( sh_req_op_o    ),
    .sh_req_arga_i  ( sh_req_arga_o  ),
    .sh_req_argb_i  ( sh_req_argb_o  ),
    .resp_valid_i   ( resp_valid_o   ),
    .resp_ready_i   ( resp_ready_i   ),
    .resp_data_i    ( resp_data_o    ),
    .resp_id_i      ( resp_id_o      ),
    .resp_error_i   ( resp_error_o   ),
    .errors_o       ( chk_errors     ),
    .done_o         ( chk_done       )
  );

  // Random back-pressure, ready high about three cycles in four
  always @(posedge clk_i) begin
    #DriveDelay;
    rnd = $random(seed);
    resp_ready_i = (rnd[1:0] != 2'b00);
    rnd = $random(seed);
    sh_req_ready_i = (rnd[1:0] != 2'b00);
  end

  // ----------------------------------------
  // Shared-unit model, answers in order
  // ----------------------------------------
  always @(posedge clk_i) begin
    sh_done = sh_resp_valid_i && sh_resp_ready_o;
    if (rst_ni && sh_req_valid_o && sh_req_ready_i) begin
      reply = reply_q.pop_front();
      pend_q.push_back({sh_req_id_o, reply});
    end
    #DriveDelay;
    if (sh_done) begin
      sh_resp_valid_i = 1'b0;
    end
    if (!sh_resp_valid_i && pend_q.size() > 0) begin
      pend = pend_q.pop_front();
      sh_resp_id_i    = pend[37:33];
      sh_resp_data_i  = pend[32:1];
      sh_resp_error_i = pend[0];
      sh_resp_valid_i = 1'b1;
    end
  end

  task automatic send_request(input integer unit, input integer op, input integer id,
                              input integer arga, input integer argb, input integer test,
                              input integer sh_data, input integer sh_err,
                              input integer edata, input integer eerr);
    int wait_cnt;
    wait_cnt = 0;
    if (unit[0]) begin
      reply_q.push_back({sh_data[31:0], sh_err[0]});
    end
    req_unit_i  = offload_pkg::unit_sel_e'(unit[0]);
    req_op_i    = op[3:0];
    req_id_i    = id[4:0];
    req_arga_i  = arga;
    req_argb_i  = argb;
    exp_test    = test[7:0];
    exp_data    = edata;
    exp_error   = eerr[0];
    req_valid_i = 1'b1;
    do begin
      @(posedge clk_i);
      wait_cnt++;
    end while (!req_ready_o && wait_cnt < ReqTimeout);
    if (!req_ready_o) begin
      $display("Timeout waiting for the DUT to accept the request of test %0d", test);
      tb_errors++;
    end else begin
      num_reqs++;
    end
    #DriveDelay;
    req_valid_i = 1'b0;
  endtask

  initial begin
    int     fd;
    int     cnt;
    int     wait_cnt;
    int     errors;
    string  line;
    integer t, u, o, id, a, b, shd, she, ed, ee;
    tb_errors   = 0;
    num_reqs    = 0;
    rst_ni      = 1'b0;
    req_valid_i = 1'b0;
    req_unit_i  = offload_pkg::UNIT_INT;
    req_id_i    = '0;
    req_op_i    = '0;
    req_arga_i  = '0;
    req_argb_i  = '0;
    exp_test    = '0;
    exp_data    = '0;
    exp_error   = 1'b0;
    repeat (10) @(posedge clk_i);
    #DriveDelay;
    rst_ni = 1'b1;

    // Reset check, outputs quiet until ready rises
    wait_cnt = 0;
    do begin
      @(posedge clk_i);
      wait_cnt++;
      if (resp_valid_o || sh_req_valid_o) begin
        $display("A valid output went high after reset before any request");
        tb_errors++;
      end
    end while (!req_ready_o && wait_cnt < RdyTimeout);
    if (!req_ready_o) begin
      $display("Timeout waiting for the request ready after reset");
      tb_errors++;
    end
    $display("test 0 %s", (tb_errors == 0) ? "passed" : "failed");
    #DriveDelay;

    fd = $fopen("verif/offload_input.txt", "r");
    if (fd == 0) begin
      $display("Could not open the stimulus file");
      tb_errors++;
    end else begin
      while ($fgets(line, fd)) begin
        if (line.len() < 2 || line[0] == "#") begin
          continue;
        end
        cnt = $sscanf(line, "%d %h %h %h %h %h %h %h %h %h",
                      t, u, o, id, a, b, shd, she, ed, ee);
        if (cnt == 10) begin
          send_request(u, o, id, a, b, t, shd, she, ed, ee);
        end
      end
      $fclose(fd);
    end

    wait_cnt = 0;
    while (chk_done < num_reqs && wait_cnt < DrainTimeout) begin
      @(posedge clk_i);
      wait_cnt++;
    end
    if (chk_done < num_reqs) begin
      $display("Timeout waiting for %0d outstanding responses", num_reqs - chk_done);
      tb_errors++;
    end
    errors = tb_errors + chk_errors + i_core_complex.i_core_complex_sva.assert_errors;
    $display("tests run: %0d, responses: %0d, errors: %0d",
             num_reqs + 1, chk_done, errors);
    if (errors == 0 && num_reqs > 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

//--- verif/offload_checker.sv
// ----------------------------------------
// Expected queues per unit, response and
// shared-request comparison
// ----------------------------------------
`timescale 1ns/1ns

module offload_checker (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        req_valid_i,
  input  logic        req_ready_i,
  input  logic        req_unit_i,
  input  logic [4:0]  req_id_i,
  input  logic [3:0]  req_op_i,
  input  logic [31:0] req_arga_i,
  input  logic [31:0] req_argb_i,
  input  logic [7:0]  exp_test_i,
  input  logic [31:0] exp_data_i,
  input  logic        exp_error_i,
  input  logic        sh_req_valid_i,
  input  logic        sh_req_ready_i,
  input  logic [4:0]  sh_req_id_i,
  input  logic [3:0]  sh_req_op_i,
  input  logic [31:0] sh_req_arga_i,
  input  logic [31:0] sh_req_argb_i,
  input  logic        resp_valid_i,
  input  logic        resp_ready_i,
  input  logic [31:0] resp_data_i,
  input  logic [4:0]  resp_id_i,
  input  logic        resp_error_i,
  output int          errors_o,
  output int          done_o
);

  // Entry layout {test, id, data, error}
  logic [45:0] int_q[$];
  logic [45:0] sh_q[$];
  // Shared request layout {id, op, arga, argb}
  logic [72:0] sh_req_q[$];
  logic [45:0] head;
  logic [72:0] sh_head;
  logic        found;

  initial begin
    errors_o = 0;
    done_o   = 0;
  end

  always @(posedge clk_i) begin
    if (rst_ni) begin
      if (req_valid_i && req_ready_i) begin
        if (req_unit_i) begin
          sh_q.push_back({exp_test_i, req_id_i, exp_data_i, exp_error_i});
          sh_req_q.push_back({req_id_i, req_op_i, req_arga_i, req_argb_i});
        end else begin
          int_q.push_back({exp_test_i, req_id_i, exp_data_i, exp_error_i});
        end
      end
      if (sh_req_valid_i && sh_req_ready_i) begin
        if (sh_req_q.size() == 0) begin
          $display("Shared request with id %0d appeared without a matching request", sh_req_id_i);
          errors_o = errors_o + 1;
        end else begin
          sh_head = sh_req_q.pop_front();
          if (sh_head !== {sh_req_id_i, sh_req_op_i, sh_req_arga_i, sh_req_argb_i}) begin
            $display("MISMATCH at %0t: shared request id %0d op %h args %h %h",
                     $time, sh_req_id_i, sh_req_op_i, sh_req_arga_i, sh_req_argb_i);
            errors_o = errors_o + 1;
          end
        end
      end
      if (resp_valid_i && resp_ready_i) begin
        found = 1'b0;
        // Each unit answers in its own order, so only the heads can match
        if (int_q.size() > 0 && int_q[0][37:33] == resp_id_i) begin
          head  = int_q.pop_front();
          found = 1'b1;
        end else if (sh_q.size() > 0 && sh_q[0][37:33] == resp_id_i) begin
          head  = sh_q.pop_front();
          found = 1'b1;
        end
        if (!found) begin
          $display("MISMATCH at %0t: response id %0d matches no pending request",
                   $time, resp_id_i);
          errors_o = errors_o + 1;
        end else if (head[32:1] !== resp_data_i || head[0] !== resp_error_i) begin
          $display("MISMATCH at %0t: test %0d got data %h error %b, expected %h error %b",
                   $time, head[45:38], resp_data_i, resp_error_i, head[32:1], head[0]);
          $display("test %0d failed", head[45:38]);
          errors_o = errors_o + 1;
          done_o   = done_o + 1;
        end else begin
          $display("test %0d passed", head[45:38]);
          done_o = done_o + 1;
        end
      end
    end
  end

endmodule

//--- verif/core_complex_sva.sv
// ----------------------------------------
// Handshake assertions on the top level
// ----------------------------------------
`timescale 1ns/1ns

module core_complex_sva #(
  parameter int unsigned DataWidth = 32,
  parameter int unsigned IdWidth   = 5
) (
  input logic                 clk_i,
  input logic                 rst_ni,
  input logic                 req_ready_o,
  input logic                 resp_valid_o,
  input logic                 resp_ready_i,
  input logic [DataWidth-1:0] resp_data_o,
  input logic [IdWidth-1:0]   resp_id_o,
  input logic                 resp_error_o,
  input logic                 sh_req_valid_o,
  input logic                 sh_req_ready_i,
  input logic [IdWidth-1:0]   sh_req_id_o,
  input logic [3:0]           sh_req_op_o,
  input logic [DataWidth-1:0] sh_req_arga_o,
  input logic [DataWidth-1:0] sh_req_argb_o
);

  // Count of failed assertions
  int assert_errors = 0;

  // Response held until accepted
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    resp_valid_o && !resp_ready_i |=> resp_valid_o &&
      $stable({resp_data_o, resp_id_o, resp_error_o}))
    else begin
      $error("response changed before it was accepted");
      assert_errors++;
    end

  // Shared request held until accepted
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    sh_req_valid_o && !sh_req_ready_i |=> sh_req_valid_o &&
      $stable({sh_req_id_o, sh_req_op_o, sh_req_arga_o, sh_req_argb_o}))
    else begin
      $error("shared request changed before it was accepted");
      assert_errors++;
    end

  assert property (@(posedge clk_i)
    !rst_ni |-> !resp_valid_o && !sh_req_valid_o && !req_ready_o)
    else begin
      $error("handshake output high during reset");
      assert_errors++;
    end

endmodule

bind core_complex core_complex_sva #(
  .DataWidth ( DataWidth ),
  .IdWidth   ( IdWidth   )
) i_core_complex_sva (.*);

//--- rtl/core_complex.sv
// ----------------------------------------
// Offload top level: request cut, switch,
// integer unit, shared port, response cut
// ----------------------------------------
`timescale 1ns/1ns

module core_complex #(
  parameter int unsigned DataWidth    = offload_pkg::DATA_W,
  parameter int unsigned IdWidth      = offload_pkg::ID_W,
  parameter bit          RegisterReq  = 1'b1,
  parameter bit          RegisterResp = 1'b1
) (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  // Offload request
  input  logic                           req_valid_i,
  input  offload_pkg::unit_sel_e         req_unit_i,
  input  logic [IdWidth-1:0]             req_id_i,
  input  logic [offload_pkg::OP_W-1:0]   req_op_i,
  input  logic [DataWidth-1:0]           req_arga_i,
  input  logic [DataWidth-1:0]           req_argb_i,
  output logic                           req_ready_o,
  // Offload response
  output logic                           resp_valid_o,
  output logic [DataWidth-1:0]           resp_data_o,
  output logic [IdWidth-1:0]             resp_id_o,
  output logic                           resp_error_o,
  input  logic                           resp_ready_i,
  // Shared-unit request
  output logic                           sh_req_valid_o,
  output logic [IdWidth-1:0]             sh_req_id_o,
  output logic [offload_pkg::OP_W-1:0]   sh_req_op_o,
  output logic [DataWidth-1:0]           sh_req_arga_o,
  output logic [DataWidth-1:0]           sh_req_argb_o,
  input  logic                           sh_req_ready_i,
  // Shared-unit response
  input  logic                           sh_resp_valid_i,
  input  logic [DataWidth-1:0]           sh_resp_data_i,
  input  logic [IdWidth-1:0]             sh_resp_id_i,
  input  logic                           sh_resp_error_i,
  output logic                           sh_resp_ready_o
);

  import offload_pkg::*;
  import ipu_pkg::*;

  localparam int unsigned ReqWidth  = 1 + IdWidth + OP_W + 2 * DataWidth;
  localparam int unsigned RespWidth = DataWidth + IdWidth + 1;

  // Request after the cut
  logic                 req_q_valid, req_q_ready;
  logic [ReqWidth-1:0]  req_q_data;
  logic                 req_q_unit;
  logic [IdWidth-1:0]   req_q_id;
  logic [OP_W-1:0]      req_q_op;
  logic [DataWidth-1:0] req_q_arga, req_q_argb;

  // Integer unit handshakes
  logic                 int_req_valid, int_req_ready;
  logic                 int_resp_valid, int_resp_ready, int_resp_error;
  logic [DataWidth-1:0] int_resp_data;
  logic [IdWidth-1:0]   int_resp_id;

  // Arbiter output, before the response cut
  logic                 arb_valid, arb_ready, arb_error;
  logic [DataWidth-1:0] arb_data;
  logic [IdWidth-1:0]   arb_id;
  logic [RespWidth-1:0] resp_q_data;

  // ----------------------------------------
  // Request path
  // ----------------------------------------
  spill_register #(
    .Width  ( ReqWidth     ),
    .Bypass ( !RegisterReq )
  ) i_spill_req (
    .clk_i   ( clk_i                                                      ),
    .rst_ni  ( rst_ni                                                     ),
    .valid_i ( req_valid_i                                                ),
    .ready_o ( req_ready_o                                                ),
    .data_i  ( {req_unit_i, req_id_i, req_op_i, req_arga_i, req_argb_i} ),
    .valid_o ( req_q_valid                                                ),
    .ready_i ( req_q_ready                                                ),
    .data_o  ( req_q_data                                                 )
  );

  assign {req_q_unit, req_q_id, req_q_op, req_q_arga, req_q_argb} = req_q_data;

  offload_switch #(
    .DataWidth ( DataWidth ),
    .IdWidth   ( IdWidth   )
  ) i_offload_switch (
    .clk_i            ( clk_i                   ),
    .rst_ni           ( rst_ni                  ),
    .req_valid_i      ( req_q_valid             ),
    .req_unit_i       ( unit_sel_e'(req_q_unit) ),
    .req_ready_o      ( req_q_ready             ),
    .int_req_valid_o  ( int_req_valid           ),
    .int_req_ready_i  ( int_req_ready           ),
    .sh_req_valid_o   ( sh_req_valid_o          ),
    .sh_req_ready_i   ( sh_req_ready_i          ),
    .int_resp_valid_i ( int_resp_valid          ),
    .int_resp_data_i  ( int_resp_data           ),
    .int_resp_id_i    ( int_resp_id             ),
    .int_resp_error_i ( int_resp_error          ),
    .int_resp_ready_o ( int_resp_ready          ),
    .sh_resp_valid_i  ( sh_resp_valid_i         ),
    .sh_resp_data_i   ( sh_resp_data_i          ),
    .sh_resp_id_i     ( sh_resp_id_i            ),
    .sh_resp_error_i  ( sh_resp_error_i         ),
    .sh_resp_ready_o  ( sh_resp_ready_o         ),
    .resp_valid_o     ( arb_valid               ),
    .resp_data_o      ( arb_data                ),
    .resp_id_o        ( arb_id                  ),
    .resp_error_o     ( arb_error               ),
    .resp_ready_i     ( arb_ready               )
  );

  int_unit #(
    .DataWidth ( DataWidth ),
    .IdWidth   ( IdWidth   )
  ) i_int_unit (
    .clk_i        ( clk_i               ),
    .rst_ni       ( rst_ni              ),
    .req_valid_i  ( int_req_valid       ),
    .req_id_i     ( req_q_id            ),
    .req_op_i     ( ipu_op_e'(req_q_op) ),
    .req_arga_i   ( req_q_arga          ),
    .req_argb_i   ( req_q_argb          ),
    .req_ready_o  ( int_req_ready       ),
    .resp_valid_o ( int_resp_valid      ),
    .resp_data_o  ( int_resp_data       ),
    .resp_id_o    ( int_resp_id         ),
    .resp_error_o ( int_resp_error      ),
    .resp_ready_i ( int_resp_ready      )
  );

  // Shared unit sees the cut request data directly
  assign sh_req_id_o   = req_q_id;
  assign sh_req_op_o   = req_q_op;
  assign sh_req_arga_o = req_q_arga;
  assign sh_req_argb_o = req_q_argb;

  // ----------------------------------------
  // Response path
  // ----------------------------------------
  spill_register #(
    .Width  ( RespWidth     ),
    .Bypass ( !RegisterResp )
  ) i_spill_resp (
    .clk_i   ( clk_i                          ),
    .rst_ni  ( rst_ni                         ),
    .valid_i ( arb_valid                      ),
    .ready_o ( arb_ready                      ),
    .data_i  ( {arb_data, arb_id, arb_error} ),
    .valid_o ( resp_valid_o                   ),
    .ready_i ( resp_ready_i                   ),
    .data_o  ( resp_q_data                    )
  );

  assign {resp_data_o, resp_id_o, resp_error_o} = resp_q_data;

endmodule

//--- rtl/int_unit.sv
// ----------------------------------------
// Two-stage integer processing unit
// Decode stage, then compute stage
// ----------------------------------------
`timescale 1ns/1ns

module int_unit #(
  parameter int unsigned DataWidth = offload_pkg::DATA_W,
  parameter int unsigned IdWidth   = offload_pkg::ID_W
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 req_valid_i,
  input  logic [IdWidth-1:0]   req_id_i,
  input  ipu_pkg::ipu_op_e     req_op_i,
  input  logic [DataWidth-1:0] req_arga_i,
  input  logic [DataWidth-1:0] req_argb_i,
  output logic                 req_ready_o,
  output logic                 resp_valid_o,
  output logic [DataWidth-1:0] resp_data_o,
  output logic [IdWidth-1:0]   resp_id_o,
  output logic                 resp_error_o,
  input  logic                 resp_ready_i
);

  import ipu_pkg::*;

  // Stage one registers
  logic                 s1_valid_q;
  logic [IdWidth-1:0]   s1_id_q;
  ipu_op_e              s1_op_q;
  logic                 s1_err_q;
  logic [DataWidth-1:0] s1_a_q, s1_b_q;
  // Stage two registers
  logic                 s2_valid_q;
  logic [IdWidth-1:0]   s2_id_q;
  logic                 s2_err_q;
  logic [DataWidth-1:0] s2_data_q;

  logic                 s1_ready, s2_ready;
  logic                 op_known;
  logic [DataWidth-1:0] alu_result;

  // A stage moves on when the next one is empty or draining
  assign s2_ready    = ~s2_valid_q | resp_ready_i;
  assign s1_ready    = ~s1_valid_q | s2_ready;
  assign req_ready_o = s1_ready;

  // ----------------------------------------
  // Decode
  // ----------------------------------------
  always_comb begin
    case (req_op_i)
      OP_ADD, OP_SUB, OP_MUL, OP_AND, OP_OR, OP_XOR, OP_SLL, OP_SRL: op_known = 1'b1;
      default: op_known = 1'b0;
    endcase
  end

  // ----------------------------------------
  // Compute
  // ----------------------------------------
  always_comb begin
    case (s1_op_q)
      OP_ADD:  alu_result = s1_a_q + s1_b_q;
      OP_SUB:  alu_result = s1_a_q - s1_b_q;
      // Low half of the product
      OP_MUL:  alu_result = s1_a_q * s1_b_q;
      OP_AND:  alu_result = s1_a_q & s1_b_q;
      OP_OR:   alu_result = s1_a_q | s1_b_q;
      OP_XOR:  alu_result = s1_a_q ^ s1_b_q;
      OP_SLL:  alu_result = s1_a_q << s1_b_q[4:0];
      OP_SRL:  alu_result = s1_a_q >> s1_b_q[4:0];
      default: alu_result = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      s1_valid_q <= 1'b0;
      s2_valid_q <= 1'b0;
    end else begin
      if (s1_ready) begin
        s1_valid_q <= req_valid_i;
      end
      if (s2_ready) begin
        s2_valid_q <= s1_valid_q;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_valid_i && s1_ready) begin
      s1_id_q  <= req_id_i;
      s1_op_q  <= req_op_i;
      s1_err_q <= ~op_known;
      s1_a_q   <= req_arga_i;
      s1_b_q   <= req_argb_i;
    end
    if (s1_valid_q && s2_ready) begin
      s2_id_q   <= s1_id_q;
      s2_err_q  <= s1_err_q;
      s2_data_q <= alu_result;
    end
  end

  assign resp_valid_o = s2_valid_q;
  assign resp_data_o  = s2_data_q;
  assign resp_id_o    = s2_id_q;
  assign resp_error_o = s2_err_q;

endmodule

//--- rtl/offload_switch.sv
// ----------------------------------------
// Request demux to integer or shared unit
// Round-robin response arbiter
// ----------------------------------------
`timescale 1ns/1ns

module offload_switch #(
  parameter int unsigned DataWidth = offload_pkg::DATA_W,
  parameter int unsigned IdWidth   = offload_pkg::ID_W
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // Request side
  input  logic                  req_valid_i,
  input  offload_pkg::unit_sel_e req_unit_i,
  output logic                  req_ready_o,
  output logic                  int_req_valid_o,
  input  logic                  int_req_ready_i,
  output logic                  sh_req_valid_o,
  input  logic                  sh_req_ready_i,
  // Response from the integer unit
  input  logic                  int_resp_valid_i,
  input  logic [DataWidth-1:0]  int_resp_data_i,
  input  logic [IdWidth-1:0]    int_resp_id_i,
  input  logic                  int_resp_error_i,
  output logic                  int_resp_ready_o,
  // Response from the shared unit
  input  logic                  sh_resp_valid_i,
  input  logic [DataWidth-1:0]  sh_resp_data_i,
  input  logic [IdWidth-1:0]    sh_resp_id_i,
  input  logic                  sh_resp_error_i,
  output logic                  sh_resp_ready_o,
  // Merged response
  output logic                  resp_valid_o,
  output logic [DataWidth-1:0]  resp_data_o,
  output logic [IdWidth-1:0]    resp_id_o,
  output logic                  resp_error_o,
  input  logic                  resp_ready_i
);

  import offload_pkg::*;

  // ----------------------------------------
  // Request steering
  // ----------------------------------------
  assign int_req_valid_o = req_valid_i & (req_unit_i == UNIT_INT);
  assign sh_req_valid_o  = req_valid_i & (req_unit_i == UNIT_SHARED);
  assign req_ready_o     = (req_unit_i == UNIT_SHARED) ? sh_req_ready_i : int_req_ready_i;

  // ----------------------------------------
  // Response arbitration
  // ----------------------------------------
  // Pointer high means the shared unit has priority
  logic rr_q;
  logic sel_sh;

  // Take the favoured source if it is valid, else the other one
  assign sel_sh = rr_q ? sh_resp_valid_i : ~int_resp_valid_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rr_q <= 1'b0;
    end else if (resp_valid_o) begin
      // Flip after a grant, follow the choice while stalled
      rr_q <= resp_ready_i ? ~sel_sh : sel_sh;
    end
  end

  assign resp_valid_o     = int_resp_valid_i | sh_resp_valid_i;
  assign resp_data_o      = sel_sh ? sh_resp_data_i : int_resp_data_i;
  assign resp_id_o        = sel_sh ? sh_resp_id_i : int_resp_id_i;
  assign resp_error_o     = sel_sh ? sh_resp_error_i : int_resp_error_i;
  assign int_resp_ready_o = resp_ready_i & ~sel_sh;
  assign sh_resp_ready_o  = resp_ready_i & sel_sh;

endmodule

//--- rtl/spill_register.sv
// ----------------------------------------
// Two-entry valid/ready cut register
// Optional bypass to plain wires
// ----------------------------------------
`timescale 1ns/1ns

module spill_register #(
  parameter int unsigned Width  = 32,
  parameter bit          Bypass = 1'b0
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             valid_i,
  output logic             ready_o,
  input  logic [Width-1:0] data_i,
  output logic             valid_o,
  input  logic             ready_i,
  output logic [Width-1:0] data_o
);

  if (Bypass) begin : gen_bypass
    assign valid_o = valid_i;
    assign ready_o = ready_i;
    assign data_o  = data_i;
  end else begin : gen_spill
    logic             a_full_q, b_full_q;
    logic             rdy_en_q;
    logic [Width-1:0] a_data_q, b_data_q;
    logic             a_fill, a_drain, b_fill, b_drain;

    // Slot A takes new data, slot B catches A when the output stalls
    assign a_fill  = valid_i & ready_o;
    assign a_drain = a_full_q & ~b_full_q;
    assign b_fill  = a_drain & ~ready_i;
    assign b_drain = b_full_q & ready_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        a_full_q <= 1'b0;
        b_full_q <= 1'b0;
        rdy_en_q <= 1'b0;
      end else begin
        // Ready held low until the first clock after reset
        rdy_en_q <= 1'b1;
        if (a_fill || a_drain) begin
          a_full_q <= a_fill;
        end
        if (b_fill || b_drain) begin
          b_full_q <= b_fill;
        end
      end
    end

    always_ff @(posedge clk_i) begin
      if (a_fill) begin
        a_data_q <= data_i;
      end
      if (b_fill) begin
        b_data_q <= a_data_q;
      end
    end

    // B always holds the older entry
    assign ready_o = rdy_en_q & (~a_full_q | ~b_full_q);
    assign valid_o = a_full_q | b_full_q;
    assign data_o  = b_full_q ? b_data_q : a_data_q;
  end

endmodule

//--- rtl/ipu_pkg.sv
// ----------------------------------------
// Integer processing unit opcodes
// ----------------------------------------

package ipu_pkg;

  // Codes 8 to 15 are unknown and answered with an error
  typedef enum logic [offload_pkg::OP_W-1:0] {
    OP_ADD = 4'h0,
    OP_SUB = 4'h1,
    OP_MUL = 4'h2,
    OP_AND = 4'h3,
    OP_OR  = 4'h4,
    OP_XOR = 4'h5,
    OP_SLL = 4'h6,
    OP_SRL = 4'h7
  } ipu_op_e;

endpackage

//--- rtl/offload_pkg.sv
// ----------------------------------------
// Offload path widths and defaults
// Unit-select encoding of the request
// ----------------------------------------

package offload_pkg;

  // ----------------------------------------
  // Widths
  // ----------------------------------------
  // Operand and result width
  parameter int unsigned DATA_W = 32;

  // Destination register id
  parameter int unsigned ID_W = 5;

  // Opcode field
  parameter int unsigned OP_W = 4;

  // ----------------------------------------
  // Request address field
  // ----------------------------------------
  // One bit, picks the unit that serves the request
  typedef enum logic [0:0] {
    UNIT_INT    = 1'b0,
    UNIT_SHARED = 1'b1
  } unit_sel_e;

endpackage
